//--- Bender.yml
package:
  name: mod_inverter

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/inv_pkg.sv
      - verilog/inv_ctrl.sv
      - verilog/inv_uv_reducer.sv
      - verilog/inv_coef_updater.sv
      - verilog/inv_normalizer.sv
      - verilog/mod_inverter.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_mod_inverter.sv

//--- bench/tb_mod_inverter.sv
`include "inv_defs.svh"

module tb_mod_inverter
    import inv_pkg::*;
();

    localparam int NUM_RANDOM = 8;
    localparam int NUM_TESTS  = 2 * (NUM_RANDOM + 3) + 6;  // random, edge, abandon, slack

    typedef logic signed [2*`INV_WIDTH+3:0] wide_t;
    typedef logic [2*`INV_WIDTH-1:0]        dbl_t;

    // 2^255 - 19 and the secp256k1 field prime
    localparam operand_t P_25519 =
        256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;
    localparam operand_t P_K1 =
        256'hffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_fffffffe_fffffc2f;

    logic     clk;
    logic     rstn;
    logic     start;
    operand_t a_in;
    operand_t p_in;
    logic     busy;
    logic     result_valid;
    operand_t a_inv;

    integer   seed;
    int       ops;
    int       value_errors;
    int       protocol_errors;
    operand_t ra;

    mod_inverter i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .start        (start),
        .a            (a_in),
        .p            (p_in),
        .busy         (busy),
        .result_valid (result_valid),
        .a_inv        (a_inv)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // protocol properties

    assert property (@(posedge clk) disable iff (!rstn) !(busy && result_valid))
        else begin
            protocol_errors++;
            $display("busy and result_valid high together at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rstn) start |=> (busy && !result_valid))
        else begin
            protocol_errors++;
            $display("start not followed by busy with result_valid low at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rstn) $rose(result_valid) |-> $fell(busy))
        else begin
            protocol_errors++;
            $display("result_valid rose without busy falling at %0t", $time);
        end

    //////////////////////////////
    // reference model

    // textbook extended euclid, t tracks the coefficient of a
    function automatic operand_t euclid_inverse(input operand_t aa, input operand_t pp);
        wide_t r0;
        wide_t r1;
        wide_t t0;
        wide_t t1;
        wide_t q;
        wide_t tmp;
        r0 = pp;
        r1 = aa;
        t0 = 0;
        t1 = 1;
        while (r1 != 0) begin
            q   = r0 / r1;
            tmp = r0 - q * r1;
            r0  = r1;
            r1  = tmp;
            tmp = t0 - q * t1;
            t0  = t1;
            t1  = tmp;
        end
        if (t0 < 0) begin
            t0 = t0 + wide_t'(pp);
        end
        return t0[`INV_WIDTH-1:0];
    endfunction

    // operand in 1 .. p-1
    task automatic random_operand(input operand_t pp, output operand_t r);
        operand_t raw;
        raw = '0;
        for (int i = 0; i < `INV_WIDTH / 32; i++) begin
            raw = {raw[`INV_WIDTH-33:0], 32'($random(seed))};
        end
        r = raw % (pp - 1) + 1;
    endtask

    //////////////////////////////
    // stimulus and checks

    task automatic pulse_start(input operand_t aa, input operand_t pp);
        @(posedge clk);
        start <= 1'b1;
        a_in  <= aa;
        p_in  <= pp;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_result(input operand_t aa, input operand_t pp, input operand_t expected);
        int       cycles;
        operand_t got;
        dbl_t     prod;
        @(negedge clk);
        cycles = 1;
        assert (!result_valid) else begin
            protocol_errors++;
            $display("result_valid still high after a new start at %0t", $time);
        end
        while (!result_valid && cycles <= `INV_MAX_CYCLES) begin
            assert (busy) else begin
                protocol_errors++;
                $display("busy low during an operation at %0t", $time);
            end
            @(negedge clk);
            cycles++;
        end
        if (!result_valid) begin
            protocol_errors++;
            $display("no result within %0d cycles at %0t", `INV_MAX_CYCLES, $time);
            return;
        end
        assert (cycles <= `INV_MAX_CYCLES) else begin
            protocol_errors++;
            $display("latency of %0d cycles is over the bound", cycles);
        end
        ops++;
        got  = a_inv;
        prod = (dbl_t'(aa) * dbl_t'(got)) % dbl_t'(pp);
        assert (got == expected) else begin
            value_errors++;
            $display("mismatch at %0t: a_inv expected %h actual %h", $time, expected, got);
        end
        assert (got < pp) else begin
            value_errors++;
            $display("a_inv %h is not below the modulus at %0t", got, $time);
        end
        assert (prod == dbl_t'(1)) else begin
            value_errors++;
            $display("mismatch at %0t: a*a_inv mod p expected 1 actual %h", $time, prod);
        end
    endtask

    // idle after completion, the result must sit still
    task automatic hold_check();
        operand_t held;
        held = a_inv;
        repeat (4) begin
            @(negedge clk);
            assert (result_valid && a_inv == held) else begin
                protocol_errors++;
                $display("result not held while idle at %0t", $time);
            end
        end
    endtask

    task automatic run_case(input operand_t pp, input operand_t aa, input operand_t expected);
        pulse_start(aa, pp);
        wait_result(aa, pp, expected);
        hold_check();
    endtask

    task automatic run_prime(input operand_t pp);
        operand_t r;
        run_case(pp, operand_t'(1), operand_t'(1));
        run_case(pp, pp - 1, pp - 1);
        run_case(pp, operand_t'(2), (pp >> 1) + 1);    // (p+1)/2 for odd p
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_operand(pp, r);
            run_case(pp, r, euclid_inverse(r, pp));
        end
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        start           = 1'b0;
        a_in            = '0;
        p_in            = '0;
        seed            = 62;
        ops             = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(negedge clk);
        assert (!busy && !result_valid && a_inv == '0) else begin
            protocol_errors++;
            $display("outputs not idle after reset at %0t", $time);
        end

        run_prime(P_25519);
        run_prime(P_K1);

        // restart while busy, the second pair wins
        random_operand(P_25519, ra);
        pulse_start(ra, P_25519);
        repeat (30) @(negedge clk);
        assert (busy) else begin
            protocol_errors++;
            $display("first operation ended before the restart at %0t", $time);
        end
        random_operand(P_K1, ra);
        pulse_start(ra, P_K1);
        wait_result(ra, P_K1, euclid_inverse(ra, P_K1));

        $display("operations %0d, value errors %0d, protocol errors %0d",
                 ops, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * (`INV_MAX_CYCLES + 10) * 40);
        $display("timeout, the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/inv_pkg.sv
verilog/inv_ctrl.sv
verilog/inv_uv_reducer.sv
verilog/inv_coef_updater.sv
verilog/inv_normalizer.sv
verilog/mod_inverter.sv
bench/tb_mod_inverter.sv

//--- verilog/inv_coef_updater.sv
`include "inv_defs.svh"

module inv_coef_updater
    import inv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  step_t    step,
    input  operand_t p,
    input  logic     quarter_u,
    input  logic     quarter_v,
    output coef_t    x1,
    output coef_t    x2
);

    operand_t p_q;      // modulus taken on load
    coef_t    p_ext;
    coef_t    p_half;   // floor(p/2)
    coef_t    p_quart;  // floor(p/4)
    coef_t    x1_div;
    coef_t    x2_div;
    coef_t    x1_sub;
    coef_t    x2_sub;

    assign p_ext   = coef_t'({2'b00, p_q});
    assign p_half  = coef_t'({3'b000, p_q[`INV_WIDTH-1:1]});
    assign p_quart = coef_t'({4'b0000, p_q[`INV_WIDTH-1:2]});

    //////////////////////////////
    // modular division

    // x / 2 or x / 4 mod p, p odd
    // the added term is (k * p + low bits) / 4 with k picked by p mod 4
    function automatic coef_t div_mod(
        input coef_t x,
        input logic  quarter,
        input coef_t ph,
        input coef_t pq,
        input logic  p_bit1
    );
        coef_t corr;
        if (!quarter) begin
            corr = x[0] ? ph + coef_t'(1) : coef_t'(0);    // (x + p) / 2 when odd
            return (x >>> 1) + corr;
        end
        case (x[1:0])
            2'b00:   corr = coef_t'(0);
            2'b10:   corr = ph + coef_t'(1);
            2'b01:   corr = p_bit1 ? pq + coef_t'(1) : pq + ph + coef_t'(1);
            default: corr = p_bit1 ? pq + ph + coef_t'(2) : pq + coef_t'(1);
        endcase
        return (x >>> 2) + corr;
    endfunction

    // (xa - xb) / 2 mod p
    // an odd difference moves toward zero by p, which keeps |x| below p
    function automatic coef_t half_diff(
        input coef_t xa,
        input coef_t xb,
        input coef_t pe
    );
        coef_t d;
        d = xa - xb;
        if (d[0]) begin
            d = d[`INV_COEF_WIDTH-1] ? d + pe : d - pe;
        end
        return d >>> 1;
    endfunction

    assign x1_div = div_mod(x1, quarter_u, p_half, p_quart, p_q[1]);
    assign x2_div = div_mod(x2, quarter_v, p_half, p_quart, p_q[1]);
    assign x1_sub = half_diff(x1, x2, p_ext);
    assign x2_sub = half_diff(x2, x1, p_ext);

    //////////////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (step == step_load) begin
            p_q <= p;
        end
    end

    // same steps as u and v, so x1 * a = u and x2 * a = v mod p
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x1 <= coef_t'(1);
            x2 <= '0;
        end else begin
            case (step)
                step_load: begin
                    x1 <= coef_t'(1);
                    x2 <= '0;
                end
                step_reduce_u: x1 <= x1_div;
                step_reduce_v: x2 <= x2_div;
                step_sub_u:    x1 <= x1_sub;
                step_sub_v:    x2 <= x2_sub;
                default: begin
                    x1 <= x1;
                    x2 <= x2;
                end
            endcase
        end
    end

endmodule

//--- verilog/inv_ctrl.sv
`include "inv_defs.svh"

module inv_ctrl
    import inv_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  start,
    input  logic  u_even,
    input  logic  v_even,
    input  logic  u_ge_v,
    input  logic  either_is_one,
    output step_t step,
    output logic  busy,
    output logic  result_valid
);

    logic done;  // last busy cycle

    assign done = busy & either_is_one;

    //////////////////////////////
    // step selection

    // start wins over a running operation
    always_comb begin
        step = step_hold;
        if (start) begin
            step = step_load;
        end else if (busy) begin
            if (either_is_one) begin
                step = step_hold;       // freeze, result is ready
            end else if (u_even) begin
                step = step_reduce_u;
            end else if (v_even) begin
                step = step_reduce_v;
            end else if (u_ge_v) begin
                step = step_sub_u;
            end else begin
                step = step_sub_v;
            end
        end
    end

    //////////////////////////////
    // status levels

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // rises on the same edge that busy falls
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result_valid <= 1'b0;
        end else if (start) begin
            result_valid <= 1'b0;   // held result dropped by a new start
        end else if (done) begin
            result_valid <= 1'b1;
        end
    end

endmodule

//--- verilog/inv_defs.svh
`ifndef INV_DEFS_SVH
`define INV_DEFS_SVH

//////////////////////////////
// widths

// modulus and operand width
`define INV_WIDTH 256

// signed coefficients, two extra bits over the modulus
`define INV_COEF_WIDTH (`INV_WIDTH + 2)

//////////////////////////////
// timing

// worst case from start to result_valid
// one load cycle, at least one bit of u times v dropped per step, one hold cycle
`define INV_MAX_CYCLES (2 * `INV_WIDTH + 4)

`endif

//--- verilog/inv_normalizer.sv
`include "inv_defs.svh"

module inv_normalizer
    import inv_pkg::*;
(
    input  logic     clk,
    input  step_t    step,
    input  operand_t p,
    input  coef_t    x1,
    input  coef_t    x2,
    input  logic     u_is_one,
    input  logic     result_valid,
    output operand_t a_inv
);

    operand_t p_q;      // loaded together with the coefficient side
    coef_t    p_ext;
    coef_t    sel;      // coefficient of whichever value reached one
    coef_t    fixed;

    always_ff @(posedge clk) begin
        if (step == step_load) begin
            p_q <= p;
        end
    end

    assign p_ext = coef_t'({2'b00, p_q});
    assign sel   = u_is_one ? x1 : x2;

    // bring into 0 .. p-1
    always_comb begin
        if (sel < 0) begin
            fixed = sel + p_ext;
        end else if (sel >= p_ext) begin
            fixed = sel - p_ext;
        end else begin
            fixed = sel;
        end
    end

    assign a_inv = result_valid ? fixed[`INV_WIDTH-1:0] : '0;  // zero until done

endmodule

//--- verilog/inv_pkg.sv
`include "inv_defs.svh"

package inv_pkg;

    // a, p, u, v and the result
    typedef logic [`INV_WIDTH-1:0] operand_t;

    // x1 and x2, kept in the open range (-p, p)
    typedef logic signed [`INV_COEF_WIDTH-1:0] coef_t;

    // one step per cycle, issued by the controller
    typedef enum logic [2:0] {
        step_hold,
        step_load,
        step_reduce_u,  // u even, divide by 2 or 4
        step_reduce_v,  // v even, divide by 2 or 4
        step_sub_u,     // both odd, u >= v
        step_sub_v      // both odd, u < v
    } step_t;

endpackage

//--- verilog/inv_uv_reducer.sv
`include "inv_defs.svh"

module inv_uv_reducer
    import inv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  step_t    step,
    input  operand_t a,
    input  operand_t p,
    output logic     u_even,
    output logic     v_even,
    output logic     u_ge_v,
    output logic     either_is_one,
    output logic     u_is_one,
    output logic     quarter_u,
    output logic     quarter_v
);

    operand_t u;
    operand_t v;
    operand_t u_div;   // u / 2 or u / 4
    operand_t v_div;
    operand_t u_sub;   // (u - v) / 2, both odd
    operand_t v_sub;
    logic     v_is_one;

    //////////////////////////////
    // status flags

    assign u_even   = ~u[0];
    assign v_even   = ~v[0];
    assign u_ge_v   = (u >= v);
    assign u_is_one = (u == operand_t'(1));
    assign v_is_one = (v == operand_t'(1));

    assign either_is_one = u_is_one | v_is_one;

    // low bits 10 allow only one halving
    // the coefficient side takes its divisor from here
    assign quarter_u = (u[1:0] == 2'b00);
    assign quarter_v = (v[1:0] == 2'b00);

    //////////////////////////////
    // next values

    assign u_div = quarter_u ? (u >> 2) : (u >> 1);
    assign v_div = quarter_v ? (v >> 2) : (v >> 1);

    // halves of two odd values, the dropped ones cancel
    assign u_sub = (u >> 1) - (v >> 1);
    assign v_sub = (v >> 1) - (u >> 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            u <= '0;
            v <= '0;
        end else begin
            case (step)
                step_load: begin
                    u <= a;
                    v <= p;
                end
                step_reduce_u: u <= u_div;
                step_reduce_v: v <= v_div;
                step_sub_u:    u <= u_sub;
                step_sub_v:    v <= v_sub;
                default: begin
                    u <= u;     // hold
                    v <= v;
                end
            endcase
        end
    end

endmodule

//--- verilog/mod_inverter.sv
`include "inv_defs.svh"

module mod_inverter
    import inv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     start,
    input  operand_t a,
    input  operand_t p,
    output logic     busy,
    output logic     result_valid,
    output operand_t a_inv
);

    step_t step;
    logic  u_even;
    logic  v_even;
    logic  u_ge_v;
    logic  either_is_one;
    logic  u_is_one;
    logic  quarter_u;
    logic  quarter_v;
    coef_t x1;
    coef_t x2;

    inv_ctrl i_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .u_even        (u_even),
        .v_even        (v_even),
        .u_ge_v        (u_ge_v),
        .either_is_one (either_is_one),
        .step          (step),
        .busy          (busy),
        .result_valid  (result_valid)
    );

    inv_uv_reducer i_uv_reducer (
        .clk           (clk),
        .rstn          (rstn),
        .step          (step),
        .a             (a),
        .p             (p),
        .u_even        (u_even),
        .v_even        (v_even),
        .u_ge_v        (u_ge_v),
        .either_is_one (either_is_one),
        .u_is_one      (u_is_one),
        .quarter_u     (quarter_u),
        .quarter_v     (quarter_v)
    );

    inv_coef_updater i_coef_updater (
        .clk       (clk),
        .rstn      (rstn),
        .step      (step),
        .p         (p),
        .quarter_u (quarter_u),
        .quarter_v (quarter_v),
        .x1        (x1),
        .x2        (x2)
    );

    inv_normalizer i_normalizer (
        .clk          (clk),
        .step         (step),
        .p            (p),
        .x1           (x1),
        .x2           (x2),
        .u_is_one     (u_is_one),
        .result_valid (result_valid),
        .a_inv        (a_inv)
    );

endmodule
